/* Bender.yml */
package:
  name: ll_axi_slave

sources:
  - common/ll_pkg.sv
  - hw/ll_rx_unpack.sv
  - ll_rx_fifo/ll_rx_fifo.sv
  - hw/ll_ar_issue.sv
  - ll_tx_link/ll_tx_link.sv
  - hw/ll_axi_slave_top.sv
  - target: simulation
    files:
      - testbench/tb_ll_axi_slave.sv

/* common/ll_pkg.sv */
// Shared definitions for the AXI slave logic link
// AXI field widths, AR and R packet types, PHY word type
// Bit positions of the incoming and outgoing PHY words
// Default receive FIFO depth

`default_nettype none

package ll_pkg;

  ////////////////////////////////////////
  // AXI field types
  typedef logic [3:0]   ar_id_t;
  typedef logic [2:0]   ar_size_t;
  typedef logic [7:0]   ar_len_t;
  typedef logic [1:0]   ar_burst_t;
  typedef logic [47:0]  axi_addr_t;
  typedef logic [1:0]   axi_resp_t;
  typedef logic [255:0] r_data_t;

  ////////////////////////////////////////
  // Packet types
  // AR packet from MSB down: id, size, len, burst, addr
  typedef logic [64:0]  ar_pkt_t;
  // R packet from MSB down: id, data, last, resp
  typedef logic [262:0] r_pkt_t;

  // One PHY transfer, unused bits zero
  typedef logic [319:0] phy_word_t;

  typedef logic [7:0]   credit_t;

  ////////////////////////////////////////
  // Incoming PHY word layout
  localparam int RX_AR_PUSH_BIT   = 0;
  localparam int RX_AR_PKT_LSB    = 1;
  localparam int RX_R_CREDIT_BIT  = 66;

  // Outgoing PHY word layout
  localparam int TX_R_PUSH_BIT    = 0;
  localparam int TX_R_PKT_LSB     = 1;
  localparam int TX_AR_CREDIT_BIT = 264;

  // Remote master starts with this many AR credits
  localparam int AR_FIFO_DEPTH_DEFAULT = 8;

endpackage

`default_nettype wire

/* hw/ll_ar_issue.sv */
// AR issue stage
// One-entry output register fed from the FIFO head
// Splits the AR packet into AXI AR fields

`timescale 1ns/1ps
`default_nettype none

module ll_ar_issue (
  input  logic              clk_wr,
  input  logic              rst_n,

  input  ll_pkg::ar_pkt_t   head,
  input  logic              head_valid,
  output logic              pop,

  output ll_pkg::ar_id_t    user_arid,
  output ll_pkg::ar_size_t  user_arsize,
  output ll_pkg::ar_len_t   user_arlen,
  output ll_pkg::ar_burst_t user_arburst,
  output ll_pkg::axi_addr_t user_araddr,
  output logic              user_arvalid,
  input  logic              user_arready
);

  ll_pkg::ar_pkt_t out_pkt;

  // Load when the slot is empty or being accepted this cycle
  assign pop = head_valid && (!user_arvalid || user_arready);

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      user_arvalid <= 1'b0;
    end else if (pop) begin
      user_arvalid <= 1'b1;
    end else if (user_arready) begin
      user_arvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (pop) begin
      out_pkt <= head;
    end
  end

  // Packet order from MSB down
  assign {user_arid, user_arsize, user_arlen, user_arburst, user_araddr} = out_pkt;

  // Stalled request holds its fields until accepted
  a_ar_stable: assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    (user_arvalid && !user_arready) |=> (user_arvalid && $stable(out_pkt))
  );

endmodule

`default_nettype wire

/* hw/ll_axi_slave_top.sv */
// AXI slave logic link top level
// Receive chain: PHY unpack, AR FIFO, AR issue stage
// Transmit link for R beats and AR credit return

`timescale 1ns/1ps
`default_nettype none

module ll_axi_slave_top #(
  parameter int AR_FIFO_DEPTH = ll_pkg::AR_FIFO_DEPTH_DEFAULT
) (
  input  logic              clk_wr,
  input  logic              rst_n,

  // Link control
  input  logic              tx_online,
  input  logic              rx_online,
  input  ll_pkg::credit_t   init_r_credit,

  // PHY
  input  ll_pkg::phy_word_t rx_phy,
  output ll_pkg::phy_word_t tx_phy,

  // AR channel
  output ll_pkg::ar_id_t    user_arid,
  output ll_pkg::ar_size_t  user_arsize,
  output ll_pkg::ar_len_t   user_arlen,
  output ll_pkg::ar_burst_t user_arburst,
  output ll_pkg::axi_addr_t user_araddr,
  output logic              user_arvalid,
  input  logic              user_arready,

  // R channel
  input  ll_pkg::ar_id_t    user_rid,
  input  ll_pkg::r_data_t   user_rdata,
  input  logic              user_rlast,
  input  ll_pkg::axi_resp_t user_rresp,
  input  logic              user_rvalid,
  output logic              user_rready
);

  logic            ar_push;
  ll_pkg::ar_pkt_t ar_pkt;
  logic            r_credit;
  ll_pkg::ar_pkt_t head;
  logic            head_valid;
  logic            pop;
  logic            ar_credit;

  ////////////////////////////////////////
  // Receive chain
  ll_rx_unpack u_rx_unpack (
    .clk_wr    (clk_wr),
    .rst_n     (rst_n),
    .rx_online (rx_online),
    .rx_phy    (rx_phy),
    .ar_push   (ar_push),
    .ar_pkt    (ar_pkt),
    .r_credit  (r_credit)
  );

  ll_rx_fifo #(
    .DEPTH (AR_FIFO_DEPTH)
  ) u_rx_fifo (
    .clk_wr     (clk_wr),
    .rst_n      (rst_n),
    .ar_push    (ar_push),
    .ar_pkt     (ar_pkt),
    .head       (head),
    .head_valid (head_valid),
    .pop        (pop),
    .ar_credit  (ar_credit)
  );

  ll_ar_issue u_ar_issue (
    .clk_wr       (clk_wr),
    .rst_n        (rst_n),
    .head         (head),
    .head_valid   (head_valid),
    .pop          (pop),
    .user_arid    (user_arid),
    .user_arsize  (user_arsize),
    .user_arlen   (user_arlen),
    .user_arburst (user_arburst),
    .user_araddr  (user_araddr),
    .user_arvalid (user_arvalid),
    .user_arready (user_arready)
  );

  ////////////////////////////////////////
  // Transmit link
  ll_tx_link u_tx_link (
    .clk_wr        (clk_wr),
    .rst_n         (rst_n),
    .tx_online     (tx_online),
    .init_r_credit (init_r_credit),
    .r_credit      (r_credit),
    .ar_credit     (ar_credit),
    .user_rid      (user_rid),
    .user_rdata    (user_rdata),
    .user_rlast    (user_rlast),
    .user_rresp    (user_rresp),
    .user_rvalid   (user_rvalid),
    .user_rready   (user_rready),
    .tx_phy        (tx_phy)
  );

endmodule

`default_nettype wire

/* hw/ll_rx_unpack.sv */
// Receive side PHY unpack stage
// Samples the incoming PHY word once per cycle
// Extracts AR pushbit, AR packet and R credit bit

`timescale 1ns/1ps
`default_nettype none

module ll_rx_unpack (
  input  logic              clk_wr,
  input  logic              rst_n,

  input  logic              rx_online,
  input  ll_pkg::phy_word_t rx_phy,

  output logic              ar_push,
  output ll_pkg::ar_pkt_t   ar_pkt,
  output logic              r_credit
);

  // Fields of the current word before the register
  logic            push_bit;
  logic            credit_bit;
  ll_pkg::ar_pkt_t pkt_field;

  assign push_bit   = rx_phy[ll_pkg::RX_AR_PUSH_BIT];
  assign credit_bit = rx_phy[ll_pkg::RX_R_CREDIT_BIT];
  assign pkt_field  = rx_phy[ll_pkg::RX_AR_PKT_LSB +: $bits(ll_pkg::ar_pkt_t)];

  ////////////////////////////////////////
  // Sample register

  // An offline link shows no traffic at all
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      ar_push  <= 1'b0;
      r_credit <= 1'b0;
      ar_pkt   <= '0;
    end else begin
      if (rx_online) begin
        ar_push  <= push_bit;
        r_credit <= credit_bit;
        ar_pkt   <= pkt_field;
      end else begin
        ar_push  <= 1'b0;
        r_credit <= 1'b0;
        ar_pkt   <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* ll_axi_slave.f */
common/ll_pkg.sv
hw/ll_rx_unpack.sv
ll_rx_fifo/ll_rx_fifo.sv
hw/ll_ar_issue.sv
ll_tx_link/ll_tx_link.sv
hw/ll_axi_slave_top.sv
testbench/tb_ll_axi_slave.sv

/* ll_rx_fifo/ll_rx_fifo.sv */
// AR receive FIFO
// Circular buffer with read/write pointers and occupancy count
// One credit pulse per pop, returned to the remote master

`timescale 1ns/1ps
`default_nettype none

module ll_rx_fifo #(
  parameter int DEPTH = ll_pkg::AR_FIFO_DEPTH_DEFAULT
) (
  input  logic            clk_wr,
  input  logic            rst_n,

  input  logic            ar_push,
  input  ll_pkg::ar_pkt_t ar_pkt,

  output ll_pkg::ar_pkt_t head,
  output logic            head_valid,
  input  logic            pop,

  output logic            ar_credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  ll_pkg::ar_pkt_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;

  assign full       = (count == CNT_W'(DEPTH));
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];

  ////////////////////////////////////////
  // Storage
  always_ff @(posedge clk_wr) begin
    if (ar_push) begin
      mem[wr_ptr] <= ar_pkt;
    end
  end

  ////////////////////////////////////////
  // Pointers, count and credit return
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      ar_credit <= 1'b0;
    end else begin
      if (ar_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      case ({ar_push, pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
      // Freed slot goes back to the sender
      ar_credit <= pop;
    end
  end

  // Remote master must respect the credits it was given
  a_no_push_full: assert property (
    @(posedge clk_wr) disable iff (!rst_n) ar_push |-> !full
  );

  // Issue stage only pops a valid head
  a_no_pop_empty: assert property (
    @(posedge clk_wr) disable iff (!rst_n) pop |-> head_valid
  );

endmodule

`default_nettype wire

/* ll_tx_link/ll_tx_link.sv */
// R transmit link
// Link state FSM and R transmit credit counter
// Packs R beats and the AR credit bit into the outgoing PHY word

`timescale 1ns/1ps
`default_nettype none

module ll_tx_link (
  input  logic              clk_wr,
  input  logic              rst_n,

  input  logic              tx_online,
  input  ll_pkg::credit_t   init_r_credit,

  input  logic              r_credit,
  input  logic              ar_credit,

  input  ll_pkg::ar_id_t    user_rid,
  input  ll_pkg::r_data_t   user_rdata,
  input  logic              user_rlast,
  input  ll_pkg::axi_resp_t user_rresp,
  input  logic              user_rvalid,
  output logic              user_rready,

  output ll_pkg::phy_word_t tx_phy
);

  typedef enum logic [0:0] {
    LINK_OFFLINE,
    LINK_ONLINE
  } link_state_t;

  link_state_t       link_state;
  ll_pkg::credit_t   r_credit_cnt;
  logic              accept;
  ll_pkg::r_pkt_t    r_pkt;
  ll_pkg::phy_word_t phy_next;

  assign user_rready = (link_state == LINK_ONLINE) && (r_credit_cnt != '0);
  assign accept      = user_rvalid && user_rready;

  ////////////////////////////////////////
  // Link state and credit counter
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      link_state   <= LINK_OFFLINE;
      r_credit_cnt <= '0;
    end else begin
      case (link_state)
        LINK_OFFLINE: begin
          // Remote buffer size is known only at bring-up
          r_credit_cnt <= init_r_credit;
          if (tx_online) begin
            link_state <= LINK_ONLINE;
          end
        end
        LINK_ONLINE: begin
          if (!tx_online) begin
            link_state <= LINK_OFFLINE;
          end
          case ({accept, r_credit})
            2'b10:   r_credit_cnt <= r_credit_cnt - 8'd1;
            2'b01:   r_credit_cnt <= r_credit_cnt + 8'd1;
            default: r_credit_cnt <= r_credit_cnt;
          endcase
        end
        default: link_state <= LINK_OFFLINE;
      endcase
    end
  end

  ////////////////////////////////////////
  // PHY word packing
  assign r_pkt = {user_rid, user_rdata, user_rlast, user_rresp};

  always_comb begin
    phy_next = '0;
    phy_next[ll_pkg::TX_R_PUSH_BIT] = accept;
    if (accept) begin
      phy_next[ll_pkg::TX_R_PKT_LSB +: $bits(ll_pkg::r_pkt_t)] = r_pkt;
    end
    // AR credits return even while the R side is offline
    phy_next[ll_pkg::TX_AR_CREDIT_BIT] = ar_credit;
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy <= '0;
    end else begin
      tx_phy <= phy_next;
    end
  end

  // Remote side never returns more credits than it was granted
  a_credit_no_wrap: assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    (link_state == LINK_ONLINE && r_credit && !accept) |-> (r_credit_cnt != '1)
  );

endmodule

`default_nettype wire

/* testbench/tb_ll_axi_slave.sv */
// Directed testbench for the AXI slave logic link
// Reset, AR delivery, back-pressure, R credits, offline link
// LCG stimulus, output monitor, compare task and watchdog

`timescale 1ns/1ps
`default_nettype none

module tb_ll_axi_slave;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  localparam int AR_DEPTH     = ll_pkg::AR_FIFO_DEPTH_DEFAULT;
  // Rough cycle budget per test with a factor of two for margin
  localparam int TEST_CYCLES  = RESET_CYCLES + 40 + 60 + 70 + 30;
  localparam int TIMEOUT_NS   = 2 * TEST_CYCLES * CLK_PERIOD;

  logic clk_wr;
  logic rst_n;
  logic tx_online;
  logic rx_online;
  ll_pkg::credit_t   init_r_credit;
  ll_pkg::phy_word_t rx_phy;
  ll_pkg::phy_word_t tx_phy;
  ll_pkg::ar_id_t    user_arid;
  ll_pkg::ar_size_t  user_arsize;
  ll_pkg::ar_len_t   user_arlen;
  ll_pkg::ar_burst_t user_arburst;
  ll_pkg::axi_addr_t user_araddr;
  logic              user_arvalid;
  logic              user_arready;
  ll_pkg::ar_id_t    user_rid;
  ll_pkg::r_data_t   user_rdata;
  logic              user_rlast;
  ll_pkg::axi_resp_t user_rresp;
  logic              user_rvalid;
  logic              user_rready;

  logic [31:0]       lcg_state;
  int                error_count;
  int                credits_seen;
  ll_pkg::ar_pkt_t   ar_got[$];
  ll_pkg::phy_word_t r_got[$];

  ll_axi_slave_top #(
    .AR_FIFO_DEPTH (AR_DEPTH)
  ) dut (
    .clk_wr (clk_wr), .rst_n (rst_n), .tx_online (tx_online), .rx_online (rx_online),
    .init_r_credit (init_r_credit), .rx_phy (rx_phy), .tx_phy (tx_phy),
    .user_arid (user_arid), .user_arsize (user_arsize), .user_arlen (user_arlen),
    .user_arburst (user_arburst), .user_araddr (user_araddr),
    .user_arvalid (user_arvalid), .user_arready (user_arready),
    .user_rid (user_rid), .user_rdata (user_rdata), .user_rlast (user_rlast),
    .user_rresp (user_rresp), .user_rvalid (user_rvalid), .user_rready (user_rready)
  );

  initial clk_wr = 1'b0;
  always #(CLK_PERIOD / 2) clk_wr = ~clk_wr;

  ////////////////////////////////////////
  // Output monitor sampled mid-cycle
  always @(negedge clk_wr) begin
    if (rst_n) begin
      if (user_arvalid && user_arready) begin
        ar_got.push_back({user_arid, user_arsize, user_arlen, user_arburst, user_araddr});
      end
      if (tx_phy[ll_pkg::TX_AR_CREDIT_BIT]) begin
        credits_seen++;
      end
      if (tx_phy[ll_pkg::TX_R_PUSH_BIT]) begin
        r_got.push_back(tx_phy);
      end
    end
  end

  ////////////////////////////////////////
  // Checking and stimulus helpers
  task stop_on_error();
    error_count++;
    $display("*** FAILED ***");
    $fatal(1, "Run stopped at first error");
  endtask

  task check_eq(input string name, input logic [319:0] got, input logic [319:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      stop_on_error();
    end
  endtask

  function logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Fields from MSB down are id, size, len, burst and addr
  function automatic ll_pkg::ar_pkt_t random_ar();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    r1 = next_random();
    r2 = next_random();
    r3 = next_random();
    return {r1[31:28], r1[27:25], r1[24:17], r1[16:15], r2[31:16], r3};
  endfunction

  // Fields from MSB down are id, data, last and resp
  function automatic ll_pkg::r_pkt_t random_beat();
    ll_pkg::r_data_t data;
    logic [31:0]     r;
    int              k;
    for (k = 0; k < 8; k++) begin
      data[k*32 +: 32] = next_random();
    end
    r = next_random();
    return {r[31:28], data, r[27], r[26:25]};
  endfunction

  function automatic ll_pkg::phy_word_t ar_word(input ll_pkg::ar_pkt_t pkt);
    ll_pkg::phy_word_t w;
    w = '0;
    w[ll_pkg::RX_AR_PUSH_BIT] = 1'b1;
    w[ll_pkg::RX_AR_PKT_LSB +: $bits(ll_pkg::ar_pkt_t)] = pkt;
    return w;
  endfunction

  function automatic ll_pkg::phy_word_t credit_word();
    ll_pkg::phy_word_t w;
    w = '0;
    w[ll_pkg::RX_R_CREDIT_BIT] = 1'b1;
    return w;
  endfunction

  function automatic ll_pkg::phy_word_t r_word(input ll_pkg::r_pkt_t pkt);
    ll_pkg::phy_word_t w;
    w = '0;
    w[ll_pkg::TX_R_PUSH_BIT] = 1'b1;
    w[ll_pkg::TX_R_PKT_LSB +: $bits(ll_pkg::r_pkt_t)] = pkt;
    return w;
  endfunction

  task clear_monitor();
    ar_got.delete();
    r_got.delete();
    credits_seen = 0;
  endtask

  function automatic int count_of(input string what);
    case (what)
      "AR transfers": return ar_got.size();
      "AR credits":   return credits_seen;
      default:        return r_got.size();
    endcase
  endfunction

  // Polls on the rising edge after the monitor has settled
  task automatic wait_for_count(input string what, input int want, input int limit);
    int cycles;
    cycles = 0;
    while (count_of(what) < want) begin
      if (cycles >= limit) begin
        $display("Timed out waiting for %0d %s, saw only %0d", want, what, count_of(what));
        stop_on_error();
      end
      cycles++;
      @(posedge clk_wr);
    end
  endtask

  task automatic present_beat(input ll_pkg::r_pkt_t pkt);
    @(posedge clk_wr);
    {user_rid, user_rdata, user_rlast, user_rresp} <= pkt;
    user_rvalid <= 1'b1;
  endtask

  // Returns just before the edge that takes the beat
  task automatic wait_beat_taken(input int limit);
    int cycles;
    cycles = 0;
    @(negedge clk_wr);
    while (!user_rready) begin
      if (cycles >= limit) begin
        $display("R beat was not accepted within %0d cycles", limit);
        stop_on_error();
      end
      cycles++;
      @(negedge clk_wr);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  task automatic reset_state_check();
    @(negedge clk_wr);
    check_eq("user_arvalid", user_arvalid, 1'b0);
    check_eq("user_rready", user_rready, 1'b0);
    check_eq("tx_phy", tx_phy, '0);
  endtask

  task automatic ar_delivery();
    ll_pkg::ar_pkt_t exp_q[$];
    ll_pkg::ar_pkt_t pkt;
    int              i;
    @(posedge clk_wr);
    rx_online    <= 1'b1;
    user_arready <= 1'b1;
    clear_monitor();
    for (i = 0; i < 10; i++) begin
      pkt = random_ar();
      exp_q.push_back(pkt);
      @(posedge clk_wr);
      rx_phy <= ar_word(pkt);
    end
    @(posedge clk_wr);
    rx_phy <= '0;
    wait_for_count("AR transfers", 10, 40);
    wait_for_count("AR credits", 10, 40);
    repeat (4) @(posedge clk_wr);
    check_eq("AR transfer count", ar_got.size(), 10);
    check_eq("AR credit count", credits_seen, 10);
    for (i = 0; i < 10; i++) begin
      check_eq("user_ar fields", ar_got[i], exp_q[i]);
    end
  endtask

  task automatic ar_back_pressure();
    ll_pkg::ar_pkt_t exp_q[$];
    ll_pkg::ar_pkt_t pkt;
    int              i;
    @(posedge clk_wr);
    user_arready <= 1'b0;
    clear_monitor();
    for (i = 0; i < AR_DEPTH; i++) begin
      pkt = random_ar();
      exp_q.push_back(pkt);
      @(posedge clk_wr);
      rx_phy <= ar_word(pkt);
    end
    @(posedge clk_wr);
    rx_phy <= '0;
    // First entry sits in the output stage and the rest wait in the FIFO
    repeat (6) begin
      @(negedge clk_wr);
      check_eq("user_arvalid", user_arvalid, 1'b1);
      check_eq("user_ar fields",
               {user_arid, user_arsize, user_arlen, user_arburst, user_araddr}, exp_q[0]);
    end
    @(posedge clk_wr);
    // Only the pop into the output stage freed a slot
    check_eq("AR credit count", credits_seen, 1);
    user_arready <= 1'b1;
    wait_for_count("AR transfers", AR_DEPTH, 40);
    wait_for_count("AR credits", AR_DEPTH, 40);
    repeat (4) @(posedge clk_wr);
    check_eq("AR transfer count", ar_got.size(), AR_DEPTH);
    check_eq("AR credit count", credits_seen, AR_DEPTH);
    for (i = 0; i < AR_DEPTH; i++) begin
      check_eq("user_ar fields", ar_got[i], exp_q[i]);
    end
  endtask

  task automatic r_credit_flow();
    ll_pkg::r_pkt_t beats[5];
    int             i;
    for (i = 0; i < 5; i++) begin
      beats[i] = random_beat();
    end
    @(posedge clk_wr);
    clear_monitor();
    init_r_credit <= 8'd3;
    @(posedge clk_wr);
    tx_online <= 1'b1;
    for (i = 0; i < 3; i++) begin
      present_beat(beats[i]);
      wait_beat_taken(10);
    end
    present_beat(beats[3]);
    // Fourth beat has to wait without credit
    repeat (8) begin
      @(negedge clk_wr);
      check_eq("user_rready", user_rready, 1'b0);
    end
    @(posedge clk_wr);
    check_eq("R word count", r_got.size(), 3);
    rx_phy <= credit_word();
    @(posedge clk_wr);
    rx_phy <= credit_word();
    @(posedge clk_wr);
    rx_phy <= '0;
    wait_beat_taken(10);
    present_beat(beats[4]);
    wait_beat_taken(10);
    @(posedge clk_wr);
    user_rvalid <= 1'b0;
    wait_for_count("R words", 5, 20);
    @(negedge clk_wr);
    check_eq("user_rready", user_rready, 1'b0);
    check_eq("R word count", r_got.size(), 5);
    for (i = 0; i < 5; i++) begin
      check_eq("tx_phy", r_got[i], r_word(beats[i]));
    end
  endtask

  task automatic offline_link();
    int i;
    @(posedge clk_wr);
    clear_monitor();
    rx_online     <= 1'b0;
    tx_online     <= 1'b0;
    init_r_credit <= 8'd4;
    present_beat(random_beat());
    for (i = 0; i < 4; i++) begin
      @(posedge clk_wr);
      rx_phy <= ar_word(random_ar()) | credit_word();
      @(negedge clk_wr);
      check_eq("user_arvalid", user_arvalid, 1'b0);
      check_eq("user_rready", user_rready, 1'b0);
    end
    @(posedge clk_wr);
    rx_phy      <= '0;
    user_rvalid <= 1'b0;
    repeat (4) @(posedge clk_wr);
    check_eq("AR transfer count", ar_got.size(), 0);
    check_eq("AR credit count", credits_seen, 0);
    check_eq("R word count", r_got.size(), 0);
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  initial begin
    lcg_state     = 32'd90;
    error_count   = 0;
    credits_seen  = 0;
    rst_n         = 1'b0;
    tx_online     = 1'b0;
    rx_online     = 1'b0;
    init_r_credit = '0;
    rx_phy        = '0;
    user_arready  = 1'b0;
    user_rid      = '0;
    user_rdata    = '0;
    user_rlast    = 1'b0;
    user_rresp    = '0;
    user_rvalid   = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_wr);
    rst_n <= 1'b1;
    reset_state_check();
    ar_delivery();
    ar_back_pressure();
    r_credit_flow();
    offline_link();
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    stop_on_error();
  end

endmodule

`default_nettype wire
